// ==== nnFixedPkg.sv ====
`default_nettype none

package nnFixedPkg;

	// signed fixed-point word shared by activations, weights and biases.
	typedef logic signed [31:0] fixedWord;

	// lowest sum bit that survives the ReLU.
	localparam int fracBits = 13;

	// width of the ReLU slice, sum bits 28 down to 13.
	localparam int resultWidth = 16;

	// non-negative ReLU output.
	typedef logic [resultWidth-1:0] resultWord;

endpackage

`default_nettype wire

// ==== nnLayerPkg.sv ====
`default_nettype none

package nnLayerPkg;

	// every neuron owns a slot of 2**slotBits memory words.
	// the memory address is the neuron number above the slot index,
	// so requester i of the arbiter is also neuron i and slot i.
	localparam int slotBits = 4;

	// top word of each slot holds the bias.
	localparam int biasIndex = (1 << slotBits) - 1;

	// weights fill the slot below the bias word.
	localparam int maxInputs = biasIndex;

	// word index within one slot.
	typedef logic [slotBits-1:0] slotIndex;

endpackage

`default_nettype wire

// ==== weightBus.sv ====
`timescale 1ns/1ps
`default_nettype none

interface weightBus;
	import nnFixedPkg::*;
	import nnLayerPkg::*;

	// request side, held by the neuron until granted.
	logic req;
	slotIndex index;

	// grant is a one-cycle strobe, rdValid follows it one cycle later.
	logic grant;
	logic rdValid;
	fixedWord rdData;

	modport neuron (
		output req,
		output index,
		input grant,
		input rdValid,
		input rdData
	);

	modport arbiter (
		input req,
		input index,
		output grant,
		output rdValid,
		output rdData
	);

endinterface

`default_nettype wire

// ==== weightMemory.sv ====
`timescale 1ns/1ps
`default_nettype none

module weightMemory #(
	parameter int neuronCount = 4,
	localparam int idBits = (neuronCount > 1) ? $clog2(neuronCount) : 1,
	localparam int addrBits = idBits + nnLayerPkg::slotBits
) (
	input logic clk,
	input logic we,
	input logic [addrBits-1:0] addr,
	input nnFixedPkg::fixedWord wdata,
	output nnFixedPkg::fixedWord rdata
);
	import nnFixedPkg::*;
	import nnLayerPkg::*;

	// one slot of weights and bias per neuron.
	localparam int depth = neuronCount << slotBits;

	fixedWord mem [depth];

	// single port, so a write cycle leaves rdata unchanged.
	always_ff @(posedge clk)
	begin
		if (we)
			mem[addr] <= wdata;
		else
			rdata <= mem[addr];
	end

endmodule

`default_nettype wire

// ==== weightArbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module weightArbiter #(
	parameter int neuronCount = 4,
	localparam int idBits = (neuronCount > 1) ? $clog2(neuronCount) : 1,
	localparam int addrBits = idBits + nnLayerPkg::slotBits
) (
	input logic clk,
	input logic reset,
	input logic hostWrite,
	input logic [addrBits-1:0] hostAddr,
	input nnFixedPkg::fixedWord hostData,
	weightBus.arbiter neurons [neuronCount]
);
	import nnFixedPkg::*;
	import nnLayerPkg::*;

	logic [neuronCount-1:0] reqVec;
	slotIndex indexVec [neuronCount];
	logic [idBits-1:0] lastGrant;
	logic [idBits-1:0] pickId;
	logic pickValid;
	logic grantAny;
	logic readPending;
	logic [idBits-1:0] readId;
	logic [addrBits-1:0] memAddr;
	fixedWord memData;

	for (genvar i = 0; i < neuronCount; i++)
	begin : gBus
		assign reqVec[i] = neurons[i].req;
		assign indexVec[i] = neurons[i].index;
		assign neurons[i].grant = grantAny && (pickId == idBits'(i));
		assign neurons[i].rdValid = readPending && (readId == idBits'(i));
		assign neurons[i].rdData = memData;
	end

	// search starts just after the neuron granted last.
	always_comb
	begin
		int cand;
		pickValid = 1'b0;
		pickId = '0;
		for (int k = 1; k <= neuronCount; k++)
		begin
			cand = (int'(lastGrant) + k) % neuronCount;
			if (!pickValid && reqVec[cand])
			begin
				pickValid = 1'b1;
				pickId = idBits'(cand);
			end
		end
	end

	// host writes always own the port in their cycle.
	assign grantAny = pickValid && !hostWrite;
	assign memAddr = hostWrite ? hostAddr : {pickId, indexVec[pickId]};

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			lastGrant <= idBits'(neuronCount - 1);
			readPending <= 1'b0;
		end
		else
		begin
			readPending <= grantAny;
			if (grantAny)
				lastGrant <= pickId;
		end
	end

	// steers the returning word to the bus that was granted.
	always_ff @(posedge clk)
	begin
		readId <= pickId;
	end

	weightMemory #(
		.neuronCount(neuronCount)
	) memory (
		.clk(clk),
		.we(hostWrite),
		.addr(memAddr),
		.wdata(hostData),
		.rdata(memData)
	);

endmodule

`default_nettype wire

// ==== neuronUnit.sv ====
`timescale 1ns/1ps
`default_nettype none

module neuronUnit #(
	parameter int inputCount = 15
) (
	input logic clk,
	input logic reset,
	input logic start,
	input nnFixedPkg::fixedWord [inputCount-1:0] acts,
	weightBus.neuron bus,
	output logic resultValid,
	output nnFixedPkg::resultWord result
);
	import nnFixedPkg::*;
	import nnLayerPkg::*;

	// weight indexes stay below the bias slot.
	localparam int weightCount = (inputCount < maxInputs) ? inputCount : maxInputs;
	localparam slotIndex lastWeight = slotIndex'(weightCount - 1);

	logic busy;
	logic req;
	logic launch;
	logic biasRead;
	slotIndex index;
	slotIndex readIndex;
	fixedWord [inputCount-1:0] actsHeld;
	fixedWord acc;
	fixedWord product;
	fixedWord term;
	fixedWord sumNext;

	assign bus.req = req;
	assign bus.index = index;

	// start counts only for an idle unit.
	assign launch = start && !busy;

	// index of the word now on rdData, captured at its grant.
	assign biasRead = (readIndex == slotIndex'(biasIndex));

	// products wrap at 32 bits, like the sums.
	assign product = $signed(actsHeld[readIndex]) * $signed(bus.rdData);
	assign term = biasRead ? bus.rdData : product;
	assign sumNext = acc + term;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			busy <= 1'b0;
			req <= 1'b0;
			resultValid <= 1'b0;
		end
		else
		begin
			resultValid <= 1'b0;
			if (launch)
			begin
				busy <= 1'b1;
				req <= 1'b1;
			end
			// bias is the last word requested.
			if (bus.grant && index == slotIndex'(biasIndex))
				req <= 1'b0;
			if (bus.rdValid && biasRead)
			begin
				busy <= 1'b0;
				resultValid <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (launch)
		begin
			actsHeld <= acts;
			acc <= '0;
			index <= '0;
		end
		else
		begin
			if (bus.grant)
			begin
				readIndex <= index;
				if (index == lastWeight)
					index <= slotIndex'(biasIndex);
				else
					index <= index + 1'b1;
			end
			if (bus.rdValid)
				acc <= sumNext;
		end
	end

	// ReLU keeps bits 28 down to 13 of a non-negative sum.
	always_ff @(posedge clk)
	begin
		if (bus.rdValid && biasRead)
		begin
			if (sumNext < 0)
				result <= '0;
			else
				result <= sumNext[fracBits+resultWidth-1:fracBits];
		end
	end

endmodule

`default_nettype wire

// ==== denseLayer.sv ====
`timescale 1ns/1ps
`default_nettype none

module denseLayer #(
	parameter int neuronCount = 4,
	parameter int inputCount = 15,
	localparam int idBits = (neuronCount > 1) ? $clog2(neuronCount) : 1,
	localparam int addrBits = idBits + nnLayerPkg::slotBits
) (
	input logic clk,
	input logic reset,
	input logic actWrite,
	input nnLayerPkg::slotIndex actIndex,
	input nnFixedPkg::fixedWord actData,
	input logic wWrite,
	input logic [addrBits-1:0] wAddr,
	input nnFixedPkg::fixedWord wData,
	input logic start,
	output logic resultValid,
	output logic [idBits-1:0] resultNeuron,
	output nnFixedPkg::resultWord resultData
);
	import nnFixedPkg::*;

	fixedWord [inputCount-1:0] actRegs;
	logic [neuronCount-1:0] unitValid;
	resultWord unitResult [neuronCount];

	weightBus bus [neuronCount] ();

	// input vector, copied by each neuron when it starts.
	always_ff @(posedge clk)
	begin
		if (reset)
			actRegs <= '0;
		else if (actWrite && actIndex < inputCount)
			actRegs[actIndex] <= actData;
	end

	weightArbiter #(
		.neuronCount(neuronCount)
	) arbiter (
		.clk(clk),
		.reset(reset),
		.hostWrite(wWrite),
		.hostAddr(wAddr),
		.hostData(wData),
		.neurons(bus)
	);

	for (genvar i = 0; i < neuronCount; i++)
	begin : gNeuron
		neuronUnit #(
			.inputCount(inputCount)
		) unit (
			.clk(clk),
			.reset(reset),
			.start(start),
			.acts(actRegs),
			.bus(bus[i]),
			.resultValid(unitValid[i]),
			.result(unitResult[i])
		);
	end

	// last grants fall in distinct cycles, so at most one unit reports at a time.
	always_comb
	begin
		resultValid = 1'b0;
		resultNeuron = '0;
		resultData = '0;
		for (int i = 0; i < neuronCount; i++)
		begin
			if (unitValid[i])
			begin
				resultValid = 1'b1;
				resultNeuron = idBits'(i);
				resultData = unitResult[i];
			end
		end
	end

endmodule

`default_nettype wire

// ==== tbDenseLayer.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbDenseLayer;

	localparam int neuronCount = 4;
	localparam int inputCount = 15;
	localparam int resultTimeout = 400;
	localparam int quietCycles = 24;

	logic clk;
	logic reset;
	logic actWrite;
	logic [3:0] actIndex;
	logic signed [31:0] actData;
	logic wWrite;
	logic [5:0] wAddr;
	logic signed [31:0] wData;
	logic start;
	logic resultValid;
	logic [1:0] resultNeuron;
	logic [15:0] resultData;

	// host-side copy of everything written into the layer.
	logic signed [31:0] actModel [inputCount];
	logic signed [31:0] wModel [neuronCount][16];
	logic [15:0] expected [neuronCount];
	logic [15:0] gotData [neuronCount];
	int gotCount [neuronCount];
	logic [15:0] lfsr;
	int errors;
	int testsRun;
	int testsFailed;
	int testStartErrors;

	denseLayer #(
		.neuronCount(neuronCount),
		.inputCount(inputCount)
	) dut (
		.clk(clk),
		.reset(reset),
		.actWrite(actWrite),
		.actIndex(actIndex),
		.actData(actData),
		.wWrite(wWrite),
		.wAddr(wAddr),
		.wData(wData),
		.start(start),
		.resultValid(resultValid),
		.resultNeuron(resultNeuron),
		.resultData(resultData)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// fibonacci LFSR with taps 16, 14, 13 and 11.
	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// weighted sum with 32-bit wraparound, then the ReLU slice.
	function automatic logic [15:0] modelResult(input int n);
		logic signed [31:0] sum;
		logic signed [31:0] prod;
		sum = wModel[n][15];
		for (int i = 0; i < inputCount; i++)
		begin
			prod = actModel[i] * wModel[n][i];
			sum = sum + prod;
		end
		if (sum < 0)
			return 16'd0;
		else
			return sum[28:13];
	endfunction

	// one LFSR step per bit, sign extended from the top bit taken.
	task automatic randomValue(input int bits, output logic signed [31:0] v);
		v = '0;
		for (int i = 0; i < bits; i++)
		begin
			lfsr = lfsrNext(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		v = v <<< (32 - bits);
		v = v >>> (32 - bits);
	endtask

	task automatic writeAct(input int i, input logic signed [31:0] v);
		actModel[i] = v;
		actWrite = 1'b1;
		actIndex = 4'(i);
		actData = v;
		@(negedge clk);
		actWrite = 1'b0;
	endtask

	task automatic writeWeight(input int n, input int k, input logic signed [31:0] v);
		wModel[n][k] = v;
		wWrite = 1'b1;
		wAddr = 6'(n * 16 + k);
		wData = v;
		@(negedge clk);
		wWrite = 1'b0;
	endtask

	task automatic pulseStart;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic computeExpected;
		for (int n = 0; n < neuronCount; n++)
			expected[n] = modelResult(n);
	endtask

	// waits for one pulse per neuron, then watches a while for extra pulses.
	task automatic collectResults;
		int waitCycles;
		int seen;
		seen = 0;
		waitCycles = 0;
		for (int n = 0; n < neuronCount; n++)
		begin
			gotCount[n] = 0;
			gotData[n] = '0;
		end
		while (seen < neuronCount && waitCycles < resultTimeout)
		begin
			@(negedge clk);
			waitCycles++;
			if (resultValid)
			begin
				gotCount[resultNeuron]++;
				gotData[resultNeuron] = resultData;
				seen++;
			end
		end
		if (seen < neuronCount)
		begin
			$display("timed out: only %0d of %0d results arrived within %0d cycles",
				seen, neuronCount, resultTimeout);
			errors++;
		end
		for (int c = 0; c < quietCycles; c++)
		begin
			@(negedge clk);
			if (resultValid)
				gotCount[resultNeuron]++;
		end
	endtask

	task automatic checkResults(input string name);
		for (int n = 0; n < neuronCount; n++)
		begin
			if (gotCount[n] != 1)
			begin
				$display("[FAIL] %s neuron %0d pulse count expected 1 actual %0d",
					name, n, gotCount[n]);
				errors++;
			end
			else if (gotData[n] !== expected[n])
			begin
				$display("[FAIL] %s neuron %0d expected 0x%04h actual 0x%04h",
					name, n, expected[n], gotData[n]);
				errors++;
			end
		end
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errors == testStartErrors)
			$display("passed: %s", name);
		else
		begin
			testsFailed++;
			$display("failed: %s with %0d errors", name, errors - testStartErrors);
		end
		testStartErrors = errors;
	endtask

	task automatic idleNoResult;
		bit seenPulse;
		seenPulse = 1'b0;
		for (int c = 0; c < 40; c++)
		begin
			@(negedge clk);
			if (resultValid)
				seenPulse = 1'b1;
		end
		if (seenPulse)
		begin
			$display("[FAIL] idleNoResult expected resultValid 0 actual 1");
			errors++;
		end
		endTest("idleNoResult");
	endtask

	task automatic knownVector;
		for (int i = 0; i < inputCount; i++)
			writeAct(i, (i + 1) * 256);
		// neuron 0 follows the reference neuron, the rest use simple ramps.
		for (int k = 0; k < inputCount; k++)
			writeWeight(0, k, 8192 - k * 1024);
		writeWeight(0, 15, 4096);
		for (int n = 1; n < neuronCount; n++)
		begin
			for (int k = 0; k < inputCount; k++)
				writeWeight(n, k, n * 512 + k * 64);
			writeWeight(n, 15, n * 8192);
		end
		computeExpected();
		pulseStart();
		collectResults();
		checkResults("knownVector");
		endTest("knownVector");
	endtask

	task automatic negativeSum;
		for (int n = 0; n < neuronCount; n++)
		begin
			for (int k = 0; k < inputCount; k++)
			begin
				if (n == 2)
					writeWeight(n, k, -(k + 1) * 700);
				else
					writeWeight(n, k, (k + 1) * 300 + n * 50);
			end
			writeWeight(n, 15, (n == 2) ? -100 : 2048);
		end
		computeExpected();
		pulseStart();
		collectResults();
		checkResults("negativeSum");
		endTest("negativeSum");
	endtask

	task automatic randomRuns;
		logic signed [31:0] v;
		for (int run = 0; run < 8; run++)
		begin
			for (int i = 0; i < inputCount; i++)
			begin
				randomValue(16, v);
				writeAct(i, v);
			end
			for (int n = 0; n < neuronCount; n++)
			begin
				for (int k = 0; k < inputCount; k++)
				begin
					randomValue(16, v);
					writeWeight(n, k, v);
				end
				randomValue(24, v);
				writeWeight(n, 15, v);
			end
			computeExpected();
			pulseStart();
			collectResults();
			checkResults("randomRuns");
		end
		endTest("randomRuns");
	endtask

	task automatic latchPriority;
		logic signed [31:0] v;
		computeExpected();
		pulseStart();
		for (int i = 0; i < inputCount; i++)
		begin
			randomValue(16, v);
			writeAct(i, v);
		end
		// 19 grants pass before the first host write, so indexes 0 to 3 are read.
		repeat (4) @(negedge clk);
		for (int n = 0; n < neuronCount; n++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				randomValue(16, v);
				writeWeight(n, k, v);
				@(negedge clk);
			end
		end
		collectResults();
		checkResults("latchPriority old values");
		computeExpected();
		pulseStart();
		collectResults();
		checkResults("latchPriority new values");
		endTest("latchPriority");
	endtask

	task automatic startWhileBusy;
		logic signed [31:0] v;
		computeExpected();
		pulseStart();
		// a unit that restarted would pick up these activations.
		for (int i = 0; i < inputCount; i++)
		begin
			randomValue(16, v);
			writeAct(i, v);
		end
		pulseStart();
		collectResults();
		checkResults("startWhileBusy");
		endTest("startWhileBusy");
	endtask

	initial
	begin
		reset = 1'b1;
		actWrite = 1'b0;
		actIndex = '0;
		actData = '0;
		wWrite = 1'b0;
		wAddr = '0;
		wData = '0;
		start = 1'b0;
		lfsr = 16'd73;
		errors = 0;
		testsRun = 0;
		testsFailed = 0;
		testStartErrors = 0;
		repeat (2) @(negedge clk);
		reset = 1'b0;

		idleNoResult();
		knownVector();
		negativeSum();
		randomRuns();
		latchPriority();
		startWhileBusy();

		$display("tests run %0d, tests failed %0d, check errors %0d",
			testsRun, testsFailed, errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== src.f ====
nnFixedPkg.sv
nnLayerPkg.sv
weightBus.sv
weightMemory.sv
weightArbiter.sv
neuronUnit.sv
denseLayer.sv
tbDenseLayer.sv
